// File: Makefile
VERILATOR ?= verilator
TOP       := nabp_projector_tb
FILELIST  := filelist.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
+incdir+include
verilog/nabp_pkg.sv
verilog/image_ram.sv
verilog/sample_fifo.sv
verilog/image_addresser.sv
verilog/projection_accumulator.sv
verilog/nabp_projector.sv
tests/nabp_projector_tb.sv

// File: include/nabp_params.svh
`ifndef NABP_PARAMS_SVH
`define NABP_PARAMS_SVH

// square image, pixels per side
`define NABP_IMAGE_SIZE 8

// rows or columns handled per partition
`define NABP_PARTITION_SIZE 2

// image size over partition size
`define NABP_NO_OF_PARTITIONS 4

`define NABP_PIXEL_WIDTH 12

// default sample buffer depth
`define NABP_FIFO_DEPTH 4

`endif

// File: tests/nabp_projector_tb.sv
`timescale 1ns/1ps
`include "nabp_params.svh"

module nabp_projector_tb;

    localparam int image_size = `NABP_IMAGE_SIZE;
    localparam int part_size = `NABP_PARTITION_SIZE;
    localparam int frame_results = 2 * image_size;

    typedef logic [nabp_pkg::sum_width-1:0] sum_t;

    logic clk;
    logic reset_n;
    logic start;
    logic load_we;
    nabp_pkg::image_addr_t load_addr;
    nabp_pkg::pixel_t load_data;
    logic done;
    logic proj_cyc;
    logic proj_stb;
    nabp_pkg::projection_t proj_dat;
    logic proj_ack;

    integer seed;
    // testbench copy of what sits in the image RAM
    nabp_pkg::pixel_t image [image_size * image_size];
    int frame_proj;
    int done_count;
    int ack_wait;
    int delay_min;
    int delay_span;
    int value_errors;
    int order_errors;
    int protocol_errors;
    int timeout_errors;

    nabp_projector nabp_projector_i
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .start     (start),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .done      (done),
        .proj_cyc  (proj_cyc),
        .proj_stb  (proj_stb),
        .proj_dat  (proj_dat),
        .proj_ack  (proj_ack)
    );

    always #5 clk = ~clk;

    task automatic expect_equal(input string name, input int got, input int expected,
                                inout int errors);
        assert (got == expected)
        else
        begin
            errors++;
            $display("ERROR: %s = 0x%h, expected 0x%h", name, got, expected);
        end
    endtask

    // row sum walks address row*N+col along a row, column sum down a column
    function automatic sum_t line_sum(input nabp_pkg::scan_mode_e mode, input int index);
        sum_t total;
        int i;
        total = '0;
        for (i = 0; i < image_size; i++)
        begin
            if (mode == nabp_pkg::scan_x)
                total = total + sum_t'(image[index * image_size + i]);
            else
                total = total + sum_t'(image[i * image_size + index]);
        end
        return total;
    endfunction

    // per partition: part_size rows, then part_size columns
    task automatic check_projection(input nabp_pkg::projection_t p);
        int part;
        int slot;
        nabp_pkg::scan_mode_e exp_mode;
        nabp_pkg::line_index_t exp_index;
        sum_t exp_sum;
        part = frame_proj / (2 * part_size);
        slot = frame_proj % (2 * part_size);
        exp_mode = (slot < part_size) ? nabp_pkg::scan_x : nabp_pkg::scan_y;
        exp_index = nabp_pkg::line_index_t'(part * part_size + slot % part_size);
        exp_sum = line_sum(exp_mode, int'(exp_index));
        assert (frame_proj < frame_results)
        else
        begin
            order_errors++;
            $display("a projection arrived after the frame was already complete");
        end
        expect_equal("proj_dat.mode", int'(p.mode), int'(exp_mode), order_errors);
        expect_equal("proj_dat.index", int'(p.index), int'(exp_index), order_errors);
        expect_equal("proj_dat.sum", int'(p.sum), int'(exp_sum), value_errors);
        frame_proj++;
    endtask

    // sink with a random number of idle cycles before each ack
    always @(negedge clk)
    begin
        if (reset_n)
            proj_ack = 1'b0;
        else if (proj_ack)
            proj_ack = 1'b0;
        else if (proj_stb && ack_wait > 0)
            ack_wait--;
        else if (proj_stb)
        begin
            expect_equal("proj_cyc", int'(proj_cyc), 1, protocol_errors);
            check_projection(proj_dat);
            proj_ack = 1'b1;
            ack_wait = delay_min + int'($unsigned($random(seed)) % (delay_span + 1));
        end
    end

    always @(negedge clk)
    begin
        if (!reset_n && done)
            done_count++;
    end

    task automatic load_image();
        int a;
        for (a = 0; a < image_size * image_size; a++)
        begin
            @(negedge clk);
            image[a] = nabp_pkg::pixel_t'($random(seed));
            load_we = 1'b1;
            load_addr = nabp_pkg::image_addr_t'(a);
            load_data = image[a];
        end
        @(negedge clk);
        load_we = 1'b0;
    endtask

    task automatic check_idle(input int cycles);
        int n;
        for (n = 0; n < cycles; n++)
        begin
            @(negedge clk);
            expect_equal("proj_cyc", int'(proj_cyc), 0, protocol_errors);
            expect_equal("proj_stb", int'(proj_stb), 0, protocol_errors);
            expect_equal("done", int'(done), 0, protocol_errors);
        end
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_for_projections(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (frame_proj < target && cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        assert (frame_proj >= target)
        else
        begin
            timeout_errors++;
            $display("timed out waiting for projection number %0d", target);
        end
    endtask

    task automatic wait_for_done(input int limit);
        int cycles;
        cycles = 0;
        while (done_count == 0 && cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        assert (done_count > 0)
        else
        begin
            timeout_errors++;
            $display("timed out waiting for the done pulse");
        end
    endtask

    task automatic run_frame(input int dmin, input int dspan, input bit restart_mid);
        @(posedge clk);
        frame_proj = 0;
        done_count = 0;
        delay_min = dmin;
        delay_span = dspan;
        pulse_start();
        if (restart_mid)
        begin
            wait_for_projections(3, 5000);
            // addresser is mid-frame, so this pulse must be ignored
            pulse_start();
        end
        wait_for_projections(frame_results, 20000);
        wait_for_done(2000);
        // room for a stray result or a second frame to show up
        repeat (100) @(posedge clk);
        expect_equal("projection count", frame_proj, frame_results, order_errors);
        expect_equal("done pulse count", done_count, 1, protocol_errors);
    endtask

    initial
    begin
        seed = 32'h7c9f5ce0;
        clk = 1'b0;
        reset_n = 1'b1;
        start = 1'b0;
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        proj_ack = 1'b0;
        ack_wait = 0;
        delay_min = 0;
        delay_span = 3;
        frame_proj = 0;
        done_count = 0;
        value_errors = 0;
        order_errors = 0;
        protocol_errors = 0;
        timeout_errors = 0;
        repeat (8) @(negedge clk);
        reset_n = 1'b0;
        load_image();
        // nothing may come out before the first start
        check_idle(20);
        run_frame(0, 3, 1'b0);
        // slow sink, samples back up into the FIFO
        run_frame(8, 16, 1'b1);
        load_image();
        run_frame(0, 4, 1'b0);
        $display("error counts: value %0d, order %0d, protocol %0d, timeout %0d",
                 value_errors, order_errors, protocol_errors, timeout_errors);
        if (value_errors + order_errors + protocol_errors + timeout_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: verilog/image_addresser.sv
`timescale 1ns/1ps
`include "nabp_params.svh"

module image_addresser
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  start,
    output logic                  done,
    output logic                  ram_cyc,
    output logic                  ram_stb,
    output nabp_pkg::image_addr_t ram_adr,
    input  logic                  ram_ack,
    input  nabp_pkg::pixel_t      ram_dat,
    output logic                  push_cyc,
    output logic                  push_stb,
    output nabp_pkg::sample_t     push_dat,
    input  logic                  push_ack
);

    localparam int image_size = `NABP_IMAGE_SIZE;
    localparam int part_size = `NABP_PARTITION_SIZE;
    localparam int no_of_parts = `NABP_NO_OF_PARTITIONS;
    localparam int scan_w = (image_size > 1) ? $clog2(image_size) : 1;
    localparam int line_w = (part_size > 1) ? $clog2(part_size) : 1;
    localparam int part_w = (no_of_parts > 1) ? $clog2(no_of_parts) : 1;

    typedef enum logic [1:0] {ready_s, delay_s, addressing_x_s, addressing_y_s} state_e;

    state_e state, next_state;
    logic push_phase;
    logic [scan_w-1:0] scan_pos;
    logic [line_w-1:0] line_pos;
    logic [part_w-1:0] pe_pos;
    nabp_pkg::image_addr_t base_addr, off_x, off_y;
    nabp_pkg::sample_t sample_q;
    nabp_pkg::scan_mode_e mode;
    logic addressing, advance;
    logic scan_done, line_done, pe_done, delay_done, frame_done;

    assign addressing = (state == addressing_x_s) || (state == addressing_y_s);
    assign mode = (state == addressing_y_s) ? nabp_pkg::scan_y : nabp_pkg::scan_x;
    assign scan_done = (scan_pos == scan_w'(image_size - 1));
    assign line_done = (line_pos == line_w'(part_size - 1));
    assign pe_done = (pe_pos == part_w'(no_of_parts - 1));
    assign delay_done = (state == delay_s) && pe_done;
    // a sample is finished once the buffer takes it
    assign advance = addressing && push_phase && push_ack;
    assign frame_done = (state == addressing_y_s) && scan_done && line_done && pe_done;

    // fetch phase talks to the RAM, push phase to the FIFO
    assign ram_cyc = addressing && !push_phase;
    assign ram_stb = ram_cyc;
    assign ram_adr = base_addr + ((mode == nabp_pkg::scan_x) ? off_x : off_y);
    assign push_cyc = addressing && push_phase;
    assign push_stb = push_cyc;
    assign push_dat = sample_q;

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (start)
                    next_state = delay_s;
            delay_s:
                if (delay_done)
                    next_state = addressing_x_s;
            addressing_x_s:
                if (advance && scan_done && line_done)
                    next_state = addressing_y_s;
            addressing_y_s:
                if (advance && scan_done && line_done)
                    next_state = pe_done ? ready_s : addressing_x_s;
            default:
                next_state = ready_s;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            state <= ready_s;
            push_phase <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            state <= next_state;
            done <= advance && frame_done;
            if (ram_cyc && ram_ack)
                push_phase <= 1'b1;
            else if (advance)
                push_phase <= 1'b0;
        end
    end

    // pixel waits here with its tags until the FIFO accepts it
    always_ff @(posedge clk)
    begin
        if (ram_cyc && ram_ack)
        begin
            sample_q.pixel <= ram_dat;
            sample_q.mode <= mode;
            sample_q.index <= nabp_pkg::line_index_t'(pe_pos * part_size + line_pos);
            sample_q.scan_last <= scan_done;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            pe_pos <= '0;
            line_pos <= '0;
            scan_pos <= '0;
            base_addr <= '0;
            off_x <= '0;
            off_y <= '0;
        end
        else
        begin
            case (state)
                ready_s:
                begin
                    pe_pos <= '0;
                    line_pos <= '0;
                    scan_pos <= '0;
                    base_addr <= '0;
                    off_x <= '0;
                    off_y <= '0;
                end
                // pe_pos doubles as the delay counter
                delay_s:
                    if (delay_done)
                        pe_pos <= '0;
                    else
                        pe_pos <= pe_pos + 1'b1;
                default:
                    if (advance)
                    begin
                        scan_pos <= scan_done ? '0 : scan_pos + 1'b1;
                        if (scan_done)
                            line_pos <= line_done ? '0 : line_pos + 1'b1;
                        if (scan_done && line_done)
                            base_addr <= '0;
                        else if (state == addressing_x_s)
                            base_addr <= base_addr + 1'b1;
                        else if (scan_done)
                            base_addr <= nabp_pkg::image_addr_t'(line_pos) + 1'b1;
                        else
                            base_addr <= base_addr + nabp_pkg::image_addr_t'(image_size);
                        // next partition after its y pass
                        if (scan_done && line_done && state == addressing_y_s)
                        begin
                            pe_pos <= pe_pos + 1'b1;
                            off_x <= off_x + nabp_pkg::image_addr_t'(part_size * image_size);
                            off_y <= off_y + nabp_pkg::image_addr_t'(part_size);
                        end
                    end
            endcase
        end
    end

    // base plus offset before it is cut to the address width
    adr_in_range: assert property (@(posedge clk) disable iff (reset_n)
        ram_stb |-> (int'(base_addr) + int'((mode == nabp_pkg::scan_x) ? off_x : off_y)
                     < image_size * image_size));

    ram_stb_held: assert property (@(posedge clk) disable iff (reset_n)
        ram_stb && !ram_ack |=> ram_stb);

    push_stb_held: assert property (@(posedge clk) disable iff (reset_n)
        push_stb && !push_ack |=> push_stb);

endmodule

// File: verilog/image_ram.sv
`timescale 1ns/1ps
`include "nabp_params.svh"

module image_ram
(
    input  logic                  clk,
    input  logic                  load_we,
    input  nabp_pkg::image_addr_t load_addr,
    input  nabp_pkg::pixel_t      load_data,
    input  logic                  ram_cyc,
    input  logic                  ram_stb,
    input  nabp_pkg::image_addr_t ram_adr,
    output logic                  ram_ack,
    output nabp_pkg::pixel_t      ram_dat
);

    localparam int depth = `NABP_IMAGE_SIZE * `NABP_IMAGE_SIZE;

    nabp_pkg::pixel_t mem [depth];

    // host fills the image before start
    always_ff @(posedge clk)
    begin
        if (load_we)
            mem[load_addr] <= load_data;
    end

    // ack and data land together one cycle after the request
    always_ff @(posedge clk)
    begin
        ram_ack <= ram_cyc && ram_stb && !ram_ack;
        ram_dat <= mem[ram_adr];
    end

    ack_needs_cyc: assert property (@(posedge clk)
        ram_ack |-> ram_cyc);

endmodule

// File: verilog/nabp_pkg.sv
`include "nabp_params.svh"

package nabp_pkg;

    localparam int image_addr_width = $clog2(`NABP_IMAGE_SIZE * `NABP_IMAGE_SIZE);
    localparam int line_index_width = $clog2(`NABP_IMAGE_SIZE);
    // room for a full line of pixels without overflow
    localparam int sum_width = `NABP_PIXEL_WIDTH + line_index_width;

    typedef logic [image_addr_width-1:0] image_addr_t;
    typedef logic [`NABP_PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [line_index_width-1:0] line_index_t;

    // x scans along a row, y scans down a column
    typedef enum logic {scan_x = 1'b0, scan_y = 1'b1} scan_mode_e;

    typedef struct packed {
        pixel_t      pixel;
        scan_mode_e  mode;
        line_index_t index;
        logic        scan_last;
    } sample_t;

    typedef struct packed {
        logic [sum_width-1:0] sum;
        scan_mode_e           mode;
        line_index_t          index;
    } projection_t;

endpackage

// File: verilog/nabp_projector.sv
`timescale 1ns/1ps
`include "nabp_params.svh"

module nabp_projector
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  start,
    input  logic                  load_we,
    input  nabp_pkg::image_addr_t load_addr,
    input  nabp_pkg::pixel_t      load_data,
    output logic                  done,
    output logic                  proj_cyc,
    output logic                  proj_stb,
    output nabp_pkg::projection_t proj_dat,
    input  logic                  proj_ack
);

    // addresser to RAM
    logic ram_cyc, ram_stb, ram_ack;
    nabp_pkg::image_addr_t ram_adr;
    nabp_pkg::pixel_t ram_dat;

    // addresser to FIFO
    logic push_cyc, push_stb, push_ack;
    nabp_pkg::sample_t push_dat;

    // FIFO to accumulator
    logic pop_cyc, pop_stb, pop_ack;
    nabp_pkg::sample_t pop_dat;

    image_addresser image_addresser_i
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .start    (start),
        .done     (done),
        .ram_cyc  (ram_cyc),
        .ram_stb  (ram_stb),
        .ram_adr  (ram_adr),
        .ram_ack  (ram_ack),
        .ram_dat  (ram_dat),
        .push_cyc (push_cyc),
        .push_stb (push_stb),
        .push_dat (push_dat),
        .push_ack (push_ack)
    );

    image_ram image_ram_i
    (
        .clk       (clk),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .ram_cyc   (ram_cyc),
        .ram_stb   (ram_stb),
        .ram_adr   (ram_adr),
        .ram_ack   (ram_ack),
        .ram_dat   (ram_dat)
    );

    sample_fifo #(.DEPTH(`NABP_FIFO_DEPTH)) sample_fifo_i
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .push_cyc (push_cyc),
        .push_stb (push_stb),
        .push_dat (push_dat),
        .push_ack (push_ack),
        .pop_cyc  (pop_cyc),
        .pop_stb  (pop_stb),
        .pop_ack  (pop_ack),
        .pop_dat  (pop_dat)
    );

    projection_accumulator projection_accumulator_i
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .pop_cyc  (pop_cyc),
        .pop_stb  (pop_stb),
        .pop_ack  (pop_ack),
        .pop_dat  (pop_dat),
        .proj_cyc (proj_cyc),
        .proj_stb (proj_stb),
        .proj_dat (proj_dat),
        .proj_ack (proj_ack)
    );

endmodule

// File: verilog/projection_accumulator.sv
`timescale 1ns/1ps

module projection_accumulator
(
    input  logic                  clk,
    input  logic                  reset_n,
    output logic                  pop_cyc,
    output logic                  pop_stb,
    input  logic                  pop_ack,
    input  nabp_pkg::sample_t     pop_dat,
    output logic                  proj_cyc,
    output logic                  proj_stb,
    output nabp_pkg::projection_t proj_dat,
    input  logic                  proj_ack
);

    logic [nabp_pkg::sum_width-1:0] sum;
    logic [nabp_pkg::sum_width-1:0] new_sum;
    logic pending;
    logic pop_req;
    nabp_pkg::projection_t result;

    assign new_sum = sum + pop_dat.pixel;

    assign pop_cyc = pop_req;
    assign pop_stb = pop_req;
    assign proj_cyc = pending;
    assign proj_stb = pending;
    assign proj_dat = result;

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            sum <= '0;
            pending <= 1'b0;
            pop_req <= 1'b0;
        end
        else if (pop_ack)
        begin
            // end of scan parks the result and stalls popping
            if (pop_dat.scan_last)
            begin
                sum <= '0;
                pending <= 1'b1;
                pop_req <= 1'b0;
            end
            else
                sum <= new_sum;
        end
        else if (!pending || proj_ack)
        begin
            pending <= 1'b0;
            pop_req <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop_ack && pop_dat.scan_last)
        begin
            result.sum <= new_sum;
            result.mode <= pop_dat.mode;
            result.index <= pop_dat.index;
        end
    end

    proj_dat_stable: assert property (@(posedge clk) disable iff (reset_n)
        proj_stb && !proj_ack |=> $stable(proj_dat));

endmodule

// File: verilog/sample_fifo.sv
`timescale 1ns/1ps
`include "nabp_params.svh"

module sample_fifo
#(
    parameter int DEPTH = `NABP_FIFO_DEPTH
)
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              push_cyc,
    input  logic              push_stb,
    input  nabp_pkg::sample_t push_dat,
    output logic              push_ack,
    input  logic              pop_cyc,
    input  logic              pop_stb,
    output logic              pop_ack,
    output nabp_pkg::sample_t pop_dat
);

    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int count_w = $clog2(DEPTH + 1);

    nabp_pkg::sample_t mem [DEPTH];
    logic [ptr_w-1:0] wr_ptr, rd_ptr;
    logic [count_w-1:0] count;
    logic full, empty;

    assign full = (count == count_w'(DEPTH));
    assign empty = (count == '0);
    // withholding ack is the back-pressure
    assign push_ack = push_cyc && push_stb && !full;
    assign pop_ack = pop_cyc && pop_stb && !empty;
    assign pop_dat = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push_ack)
            mem[wr_ptr] <= push_dat;
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push_ack)
                wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop_ack)
                rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // simultaneous push and pop leaves the count alone
            case ({push_ack, pop_ack})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    count_bounded: assert property (@(posedge clk) disable iff (reset_n)
        count <= count_w'(DEPTH));

    // equal pointers mean empty unless the buffer is full
    no_pop_when_empty: assert property (@(posedge clk) disable iff (reset_n)
        pop_ack |-> ((rd_ptr != wr_ptr) || full));

endmodule
